// ==== hdl/decode_pkg.sv ====
`default_nettype none

package decode_pkg;

    // --------------------------------------------------
    // instruction word views
    // --------------------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rtype_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } itype_t;

    typedef struct packed {
        logic [6:0] imm_hi;  // imm[11:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;  // imm[4:0]
        logic [6:0] opcode;
    } stype_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } utype_t;

    typedef union packed {
        rtype_t rtype;
        itype_t itype;
        stype_t stype;
        utype_t utype;
    } instr_u;

    // major opcodes
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;
    localparam logic [6:0] OPCODE_STORE  = 7'b0100011;
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
    localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
    localparam logic [6:0] OPCODE_JALR   = 7'b1100111;
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
    localparam logic [6:0] OPCODE_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;

    // --------------------------------------------------
    // decode result encodings
    // --------------------------------------------------
    typedef enum logic [2:0] {
        NONE, ALU, LOAD, STORE, CTRL_FLOW, CSR
    } fu_t;

    typedef enum logic [5:0] {
        ADD, SUB, SLTS, SLTU, XORL, ORL, ANDL, SLL, SRL, SRA,  // alu
        LB, LH, LW, LD, LBU, LHU, LWU,                         // loads
        SB, SH, SW, SD,                                        // stores
        EQ, NE, LTS, GES, LTU, GEU,                            // branches
        JALR, SRET, MRET, WFI
    } op_t;

    typedef enum logic [2:0] {
        NOIMM, IIMM, SIMM, SBIMM, UIMM, JIMM
    } imm_sel_t;

    typedef enum logic [1:0] {
        PRIV_LVL_U = 2'd0,
        PRIV_LVL_S = 2'd1,
        PRIV_LVL_M = 2'd3
    } priv_lvl_t;

    // synchronous exception causes
    localparam logic [5:0] ILLEGAL_INSTR  = 6'd2;
    localparam logic [5:0] BREAKPOINT     = 6'd3;
    localparam logic [5:0] ENV_CALL_UMODE = 6'd8;
    localparam logic [5:0] ENV_CALL_SMODE = 6'd9;
    localparam logic [5:0] ENV_CALL_MMODE = 6'd11;

    localparam logic [1:0] MODE_REG_ADDR = 2'd0;  // word address

endpackage

`default_nettype wire

// ==== hdl/priv_mode_regs.sv ====
`default_nettype none

module priv_mode_regs (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_we_i,
    input  logic [1:0]            wb_adr_i,
    input  logic [31:0]           wb_dat_i,
    input  logic [3:0]            wb_sel_i,
    output logic [31:0]           wb_dat_o,
    output logic                  wb_ack_o,
    output decode_pkg::priv_lvl_t priv_lvl_o,
    output logic                  tw_o,
    output logic                  tsr_o
);
    logic                  wb_req;
    logic                  ack_q;
    logic                  done_q;  // current strobe already acknowledged
    logic                  adr_hit;
    logic                  wr_en;
    decode_pkg::priv_lvl_t priv_lvl_q;
    logic                  tw_q;
    logic                  tsr_q;

    assign wb_req  = wb_cyc_i & wb_stb_i;
    assign adr_hit = (wb_adr_i == decode_pkg::MODE_REG_ADDR);
    // write lands on the edge that raises ack
    assign wr_en   = wb_req & ~ack_q & ~done_q & wb_we_i & wb_sel_i[0] & adr_hit;

    // --------------------------------------------------
    // single-cycle ack, low again until strobe drops
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ack_q  <= 1'b0;
            done_q <= 1'b0;
        end else begin
            ack_q  <= wb_req & ~ack_q & ~done_q;
            done_q <= wb_req & (ack_q | done_q);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            priv_lvl_q <= decode_pkg::PRIV_LVL_M;
            tw_q       <= 1'b0;
            tsr_q      <= 1'b0;
        end else if (wr_en) begin
            // reserved encoding 2 becomes M mode
            if (wb_dat_i[1:0] == 2'd2)
                priv_lvl_q <= decode_pkg::PRIV_LVL_M;
            else
                priv_lvl_q <= decode_pkg::priv_lvl_t'(wb_dat_i[1:0]);
            tw_q  <= wb_dat_i[2];
            tsr_q <= wb_dat_i[3];
        end
    end

    assign wb_dat_o   = adr_hit ? {28'b0, tsr_q, tw_q, priv_lvl_q} : 32'b0;
    assign wb_ack_o   = ack_q;
    assign priv_lvl_o = priv_lvl_q;
    assign tw_o       = tw_q;
    assign tsr_o      = tsr_q;

endmodule

`default_nettype wire

// ==== hdl/opcode_decoder.sv ====
`default_nettype none

module opcode_decoder (
    input  logic [31:0]           instr_i,
    input  decode_pkg::priv_lvl_t priv_lvl_i,
    input  logic                  tw_i,
    input  logic                  tsr_i,
    output decode_pkg::fu_t       fu_o,
    output decode_pkg::op_t       op_o,
    output logic [4:0]            rs1_o,
    output logic [4:0]            rs2_o,
    output logic [4:0]            rd_o,
    output decode_pkg::imm_sel_t  imm_sel_o,
    output logic                  use_pc_o,
    output logic                  illegal_o,
    output logic                  ecall_o,
    output logic                  ebreak_o
);
    decode_pkg::instr_u instr;

    assign instr = instr_i;

    always_comb begin
        fu_o      = decode_pkg::NONE;
        op_o      = decode_pkg::ADD;
        rs1_o     = 5'b0;
        rs2_o     = 5'b0;
        rd_o      = 5'b0;
        imm_sel_o = decode_pkg::NOIMM;
        use_pc_o  = 1'b0;
        illegal_o = 1'b0;
        ecall_o   = 1'b0;
        ebreak_o  = 1'b0;

        case (instr.rtype.opcode)
            // --------------------------------------------------
            // privileged system group
            // --------------------------------------------------
            decode_pkg::OPCODE_SYSTEM: begin
                fu_o  = decode_pkg::CSR;
                rs1_o = instr.itype.rs1;
                rd_o  = instr.itype.rd;
                if (instr.itype.funct3 != 3'b000 || instr.itype.rs1 != 5'b0 ||
                        instr.itype.rd != 5'b0)
                    illegal_o = 1'b1;  // csr ops not supported
                case (instr.itype.imm)
                    12'h000: ecall_o  = 1'b1;
                    12'h001: ebreak_o = 1'b1;
                    12'h102: begin
                        op_o = decode_pkg::SRET;
                        if (priv_lvl_i == decode_pkg::PRIV_LVL_U ||
                                (priv_lvl_i == decode_pkg::PRIV_LVL_S && tsr_i)) begin
                            illegal_o = 1'b1;
                            op_o      = decode_pkg::ADD;  // keep mode unchanged
                        end
                    end
                    12'h302: begin
                        op_o = decode_pkg::MRET;
                        if (priv_lvl_i != decode_pkg::PRIV_LVL_M)
                            illegal_o = 1'b1;
                    end
                    12'h105: begin
                        op_o = decode_pkg::WFI;
                        if (priv_lvl_i == decode_pkg::PRIV_LVL_U ||
                                (priv_lvl_i == decode_pkg::PRIV_LVL_S && tw_i)) begin
                            illegal_o = 1'b1;
                            op_o      = decode_pkg::ADD;
                        end
                    end
                    default: illegal_o = 1'b1;
                endcase
            end

            // --------------------------------------------------
            // alu, reg-reg and reg-imm
            // --------------------------------------------------
            decode_pkg::OPCODE_OP: begin
                fu_o  = decode_pkg::ALU;
                rs1_o = instr.rtype.rs1;
                rs2_o = instr.rtype.rs2;
                rd_o  = instr.rtype.rd;
                case ({instr.rtype.funct7, instr.rtype.funct3})
                    {7'b000_0000, 3'b000}: op_o = decode_pkg::ADD;
                    {7'b010_0000, 3'b000}: op_o = decode_pkg::SUB;
                    {7'b000_0000, 3'b010}: op_o = decode_pkg::SLTS;
                    {7'b000_0000, 3'b011}: op_o = decode_pkg::SLTU;
                    {7'b000_0000, 3'b100}: op_o = decode_pkg::XORL;
                    {7'b000_0000, 3'b110}: op_o = decode_pkg::ORL;
                    {7'b000_0000, 3'b111}: op_o = decode_pkg::ANDL;
                    {7'b000_0000, 3'b001}: op_o = decode_pkg::SLL;
                    {7'b000_0000, 3'b101}: op_o = decode_pkg::SRL;
                    {7'b010_0000, 3'b101}: op_o = decode_pkg::SRA;
                    default: illegal_o = 1'b1;
                endcase
            end

            decode_pkg::OPCODE_OPIMM: begin
                fu_o      = decode_pkg::ALU;
                imm_sel_o = decode_pkg::IIMM;
                rs1_o     = instr.itype.rs1;
                rd_o      = instr.itype.rd;
                case (instr.itype.funct3)
                    3'b000: op_o = decode_pkg::ADD;
                    3'b010: op_o = decode_pkg::SLTS;
                    3'b011: op_o = decode_pkg::SLTU;
                    3'b100: op_o = decode_pkg::XORL;
                    3'b110: op_o = decode_pkg::ORL;
                    3'b111: op_o = decode_pkg::ANDL;
                    3'b001: begin
                        op_o = decode_pkg::SLL;
                        if (instr.itype.imm[11:6] != 6'b0)
                            illegal_o = 1'b1;  // shamt is 6 bits on rv64
                    end
                    default: begin  // 3'b101
                        if (instr.itype.imm[11:6] == 6'b00_0000)
                            op_o = decode_pkg::SRL;
                        else if (instr.itype.imm[11:6] == 6'b01_0000)
                            op_o = decode_pkg::SRA;
                        else
                            illegal_o = 1'b1;
                    end
                endcase
            end

            // --------------------------------------------------
            // memory
            // --------------------------------------------------
            decode_pkg::OPCODE_LOAD: begin
                fu_o      = decode_pkg::LOAD;
                imm_sel_o = decode_pkg::IIMM;
                rs1_o     = instr.itype.rs1;
                rd_o      = instr.itype.rd;
                case (instr.itype.funct3)
                    3'b000:  op_o = decode_pkg::LB;
                    3'b001:  op_o = decode_pkg::LH;
                    3'b010:  op_o = decode_pkg::LW;
                    3'b011:  op_o = decode_pkg::LD;
                    3'b100:  op_o = decode_pkg::LBU;
                    3'b101:  op_o = decode_pkg::LHU;
                    3'b110:  op_o = decode_pkg::LWU;
                    default: illegal_o = 1'b1;
                endcase
            end

            decode_pkg::OPCODE_STORE: begin
                fu_o      = decode_pkg::STORE;
                imm_sel_o = decode_pkg::SIMM;
                rs1_o     = instr.stype.rs1;
                rs2_o     = instr.stype.rs2;
                case (instr.stype.funct3)
                    3'b000:  op_o = decode_pkg::SB;
                    3'b001:  op_o = decode_pkg::SH;
                    3'b010:  op_o = decode_pkg::SW;
                    3'b011:  op_o = decode_pkg::SD;
                    default: illegal_o = 1'b1;
                endcase
            end

            // --------------------------------------------------
            // control flow and upper immediates
            // --------------------------------------------------
            decode_pkg::OPCODE_BRANCH: begin
                fu_o      = decode_pkg::CTRL_FLOW;
                imm_sel_o = decode_pkg::SBIMM;
                rs1_o     = instr.stype.rs1;
                rs2_o     = instr.stype.rs2;
                case (instr.stype.funct3)
                    3'b000:  op_o = decode_pkg::EQ;
                    3'b001:  op_o = decode_pkg::NE;
                    3'b100:  op_o = decode_pkg::LTS;
                    3'b101:  op_o = decode_pkg::GES;
                    3'b110:  op_o = decode_pkg::LTU;
                    3'b111:  op_o = decode_pkg::GEU;
                    default: illegal_o = 1'b1;
                endcase
            end

            decode_pkg::OPCODE_JALR: begin
                fu_o      = decode_pkg::CTRL_FLOW;
                op_o      = decode_pkg::JALR;
                imm_sel_o = decode_pkg::IIMM;
                rs1_o     = instr.itype.rs1;
                rd_o      = instr.itype.rd;
                if (instr.itype.funct3 != 3'b000)
                    illegal_o = 1'b1;
            end

            decode_pkg::OPCODE_JAL: begin
                fu_o      = decode_pkg::CTRL_FLOW;  // op stays ADD
                imm_sel_o = decode_pkg::JIMM;
                rd_o      = instr.utype.rd;
            end

            decode_pkg::OPCODE_AUIPC: begin
                fu_o      = decode_pkg::ALU;
                imm_sel_o = decode_pkg::UIMM;
                use_pc_o  = 1'b1;
                rd_o      = instr.utype.rd;
            end

            decode_pkg::OPCODE_LUI: begin
                fu_o      = decode_pkg::ALU;
                imm_sel_o = decode_pkg::UIMM;
                rd_o      = instr.utype.rd;
            end

            default: illegal_o = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/imm_gen.sv ====
`default_nettype none

module imm_gen #(
    parameter int XLEN = 64
) (
    input  logic [31:0]          instr_i,
    input  decode_pkg::imm_sel_t imm_sel_i,
    output logic [XLEN-1:0]      imm_o,
    output logic                 use_imm_o
);
    decode_pkg::instr_u instr;
    logic signed [11:0] imm_i;
    logic signed [11:0] imm_s;
    logic signed [12:0] imm_b;
    logic signed [31:0] imm_u;
    logic signed [20:0] imm_j;

    assign instr = instr_i;

    // raw fields, bit 31 is the sign in every format
    assign imm_i = instr.itype.imm;
    assign imm_s = {instr.stype.imm_hi, instr.stype.imm_lo};
    assign imm_b = {instr.stype.imm_hi[6], instr.stype.imm_lo[0],
                    instr.stype.imm_hi[5:0], instr.stype.imm_lo[4:1], 1'b0};
    assign imm_u = {instr.utype.imm, 12'b0};
    assign imm_j = {instr.utype.imm[19], instr.utype.imm[7:0], instr.utype.imm[8],
                    instr.utype.imm[18:9], 1'b0};

    always_comb begin
        use_imm_o = 1'b1;
        case (imm_sel_i)
            decode_pkg::IIMM:  imm_o = XLEN'(imm_i);
            decode_pkg::SIMM:  imm_o = XLEN'(imm_s);
            decode_pkg::SBIMM: imm_o = XLEN'(imm_b);
            decode_pkg::UIMM:  imm_o = XLEN'(imm_u);  // lui / auipc
            decode_pkg::JIMM:  imm_o = XLEN'(imm_j);
            default: begin
                imm_o     = '0;
                use_imm_o = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/decode_stage.sv ====
`default_nettype none

module decode_stage #(
    parameter int XLEN = 64
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    // instruction in
    input  logic                 instr_valid_i,
    input  logic [31:0]          instr_i,
    // wishbone, mode register
    input  logic                 wb_cyc_i,
    input  logic                 wb_stb_i,
    input  logic                 wb_we_i,
    input  logic [1:0]           wb_adr_i,
    input  logic [31:0]          wb_dat_i,
    input  logic [3:0]           wb_sel_i,
    output logic [31:0]          wb_dat_o,
    output logic                 wb_ack_o,
    // decoded instruction out
    output logic                 dec_valid_o,
    output decode_pkg::fu_t      fu_o,
    output decode_pkg::op_t      op_o,
    output logic [4:0]           rs1_o,
    output logic [4:0]           rs2_o,
    output logic [4:0]           rd_o,
    output logic [XLEN-1:0]      imm_o,
    output logic                 use_imm_o,
    output logic                 use_pc_o,
    output logic                 ex_valid_o,
    output logic [5:0]           ex_cause_o
);
    decode_pkg::priv_lvl_t priv_lvl;
    logic                  tw;
    logic                  tsr;
    decode_pkg::fu_t       fu;
    decode_pkg::op_t       op;
    logic [4:0]            rs1;
    logic [4:0]            rs2;
    logic [4:0]            rd;
    decode_pkg::imm_sel_t  imm_sel;
    logic                  use_pc;
    logic                  illegal;
    logic                  ecall;
    logic                  ebreak;
    logic [XLEN-1:0]       imm;
    logic                  use_imm;
    logic                  ex_valid;
    logic [5:0]            ex_cause;

    priv_mode_regs priv_mode_regs_inst (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .wb_cyc_i   (wb_cyc_i),
        .wb_stb_i   (wb_stb_i),
        .wb_we_i    (wb_we_i),
        .wb_adr_i   (wb_adr_i),
        .wb_dat_i   (wb_dat_i),
        .wb_sel_i   (wb_sel_i),
        .wb_dat_o   (wb_dat_o),
        .wb_ack_o   (wb_ack_o),
        .priv_lvl_o (priv_lvl),
        .tw_o       (tw),
        .tsr_o      (tsr)
    );

    opcode_decoder opcode_decoder_inst (
        .instr_i    (instr_i),
        .priv_lvl_i (priv_lvl),
        .tw_i       (tw),
        .tsr_i      (tsr),
        .fu_o       (fu),
        .op_o       (op),
        .rs1_o      (rs1),
        .rs2_o      (rs2),
        .rd_o       (rd),
        .imm_sel_o  (imm_sel),
        .use_pc_o   (use_pc),
        .illegal_o  (illegal),
        .ecall_o    (ecall),
        .ebreak_o   (ebreak)
    );

    imm_gen #(
        .XLEN (XLEN)
    ) imm_gen_inst (
        .instr_i   (instr_i),
        .imm_sel_i (imm_sel),
        .imm_o     (imm),
        .use_imm_o (use_imm)
    );

    // --------------------------------------------------
    // exception priority: illegal > ecall > ebreak
    // --------------------------------------------------
    always_comb begin
        ex_valid = illegal | ecall | ebreak;
        ex_cause = decode_pkg::BREAKPOINT;
        if (illegal) begin
            ex_cause = decode_pkg::ILLEGAL_INSTR;
        end else if (ecall) begin
            case (priv_lvl)  // cause follows current mode
                decode_pkg::PRIV_LVL_M: ex_cause = decode_pkg::ENV_CALL_MMODE;
                decode_pkg::PRIV_LVL_S: ex_cause = decode_pkg::ENV_CALL_SMODE;
                default:                ex_cause = decode_pkg::ENV_CALL_UMODE;
            endcase
        end
    end

    // output register
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            dec_valid_o <= 1'b0;
            ex_valid_o  <= 1'b0;
        end else begin
            dec_valid_o <= instr_valid_i;
            ex_valid_o  <= instr_valid_i & ex_valid;  // only with a valid decode
        end
    end

    always_ff @(posedge clk_i) begin
        if (instr_valid_i) begin
            fu_o       <= fu;
            op_o       <= op;
            rs1_o      <= rs1;
            rs2_o      <= rs2;
            rd_o       <= rd;
            imm_o      <= imm;
            use_imm_o  <= use_imm;
            use_pc_o   <= use_pc;
            ex_cause_o <= ex_cause;
        end
    end

endmodule

`default_nettype wire

// ==== sim/decode_stage_sva.sv ====
`default_nettype none

module decode_stage_sva (
    input logic clk_i,
    input logic rst_i,
    input logic instr_valid_i,
    input logic dec_valid_o,
    input logic ex_valid_o,
    input logic wb_cyc_i,
    input logic wb_stb_i,
    input logic wb_ack_o
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;  // failed assertions so far

    valid_latency_a: assert property (@(posedge clk_i) disable iff (rst_i)
        dec_valid_o == $past(instr_valid_i))
        else begin
            $error("dec_valid_o does not follow instr_valid_i by one cycle");
            fail_count++;
        end

    // ack is a single pulse
    ack_pulse_a: assert property (@(posedge clk_i) disable iff (rst_i)
        wb_ack_o |=> !wb_ack_o)
        else begin
            $error("wb_ack_o high two cycles in a row");
            fail_count++;
        end

    ack_after_stb_a: assert property (@(posedge clk_i) disable iff (rst_i)
        wb_ack_o |-> $past(wb_cyc_i && wb_stb_i))
        else begin
            $error("wb_ack_o without a strobe in the previous cycle");
            fail_count++;
        end

    ex_needs_valid_a: assert property (@(posedge clk_i) disable iff (rst_i)
        !dec_valid_o |-> !ex_valid_o)
        else begin
            $error("ex_valid_o set without dec_valid_o");
            fail_count++;
        end

endmodule

bind decode_stage decode_stage_sva decode_stage_sva_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .instr_valid_i (instr_valid_i),
    .dec_valid_o   (dec_valid_o),
    .ex_valid_o    (ex_valid_o),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_ack_o      (wb_ack_o)
);

`default_nettype wire

// ==== sim/decode_stage_tb.sv ====
`default_nettype none

module decode_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int XLEN = 64;

    logic                  clk_i;
    logic                  rst_i;
    logic                  instr_valid_i;
    logic [31:0]           instr_i;
    logic                  wb_cyc_i;
    logic                  wb_stb_i;
    logic                  wb_we_i;
    logic [1:0]            wb_adr_i;
    logic [31:0]           wb_dat_i;
    logic [3:0]            wb_sel_i;
    logic [31:0]           wb_dat_o;
    logic                  wb_ack_o;
    logic                  dec_valid_o;
    decode_pkg::fu_t       fu_o;
    decode_pkg::op_t       op_o;
    logic [4:0]            rs1_o;
    logic [4:0]            rs2_o;
    logic [4:0]            rd_o;
    logic [XLEN-1:0]       imm_o;
    logic                  use_imm_o;
    logic                  use_pc_o;
    logic                  ex_valid_o;
    logic [5:0]            ex_cause_o;

    int error_count = 0;
    int cycle_count = 0;
    int cycle_limit = 0;
    int line_count  = 0;

    // fields of the line just read, and of the instruction in flight
    logic [31:0] new_instr;
    logic [2:0]  new_fu;
    logic [5:0]  new_op;
    logic [4:0]  new_rd, new_rs1, new_rs2;
    logic [63:0] new_imm;
    logic        new_use_imm, new_use_pc, new_ex_valid;
    logic [5:0]  new_ex_cause;
    bit          pending = 1'b0;
    logic [2:0]  pend_fu;
    logic [5:0]  pend_op;
    logic [4:0]  pend_rd, pend_rs1, pend_rs2;
    logic [63:0] pend_imm;
    logic        pend_use_imm, pend_use_pc, pend_ex_valid;
    logic [5:0]  pend_ex_cause;

    decode_stage #(
        .XLEN (XLEN)
    ) decode_stage_inst (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_we_i       (wb_we_i),
        .wb_adr_i      (wb_adr_i),
        .wb_dat_i      (wb_dat_i),
        .wb_sel_i      (wb_sel_i),
        .wb_dat_o      (wb_dat_o),
        .wb_ack_o      (wb_ack_o),
        .dec_valid_o   (dec_valid_o),
        .fu_o          (fu_o),
        .op_o          (op_o),
        .rs1_o         (rs1_o),
        .rs2_o         (rs2_o),
        .rd_o          (rd_o),
        .imm_o         (imm_o),
        .use_imm_o     (use_imm_o),
        .use_pc_o      (use_pc_o),
        .ex_valid_o    (ex_valid_o),
        .ex_cause_o    (ex_cause_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;  // 100 ns period
    end

    // watchdog
    initial begin
        forever begin
            @(posedge clk_i);
            cycle_count++;
            if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
                $display("run timed out after %0d cycles", cycle_count);
                $display("TEST RESULT: FAIL");
                $fatal(1);
            end
        end
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %s expected 0x%0h got 0x%0h", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    // --------------------------------------------------
    // decode path
    // --------------------------------------------------
    task automatic check_outputs();
        check_value("dec_valid_o", 64'd1, 64'(dec_valid_o));
        check_value("fu_o", 64'(pend_fu), 64'(fu_o));
        check_value("op_o", 64'(pend_op), 64'(op_o));
        check_value("rd_o", 64'(pend_rd), 64'(rd_o));
        check_value("rs1_o", 64'(pend_rs1), 64'(rs1_o));
        check_value("rs2_o", 64'(pend_rs2), 64'(rs2_o));
        check_value("imm_o", pend_imm, 64'(imm_o));
        check_value("use_imm_o", 64'(pend_use_imm), 64'(use_imm_o));
        check_value("use_pc_o", 64'(pend_use_pc), 64'(use_pc_o));
        check_value("ex_valid_o", 64'(pend_ex_valid), 64'(ex_valid_o));
        if (pend_ex_valid)
            check_value("ex_cause_o", 64'(pend_ex_cause), 64'(ex_cause_o));
    endtask

    // check the previous instruction, then present the next one
    task automatic drive_instr();
        @(negedge clk_i);
        if (pending)
            check_outputs();
        instr_valid_i = 1'b1;
        instr_i       = new_instr;
        pend_fu       = new_fu;
        pend_op       = new_op;
        pend_rd       = new_rd;
        pend_rs1      = new_rs1;
        pend_rs2      = new_rs2;
        pend_imm      = new_imm;
        pend_use_imm  = new_use_imm;
        pend_use_pc   = new_use_pc;
        pend_ex_valid = new_ex_valid;
        pend_ex_cause = new_ex_cause;
        pending       = 1'b1;
    endtask

    task automatic flush_pending();
        if (pending) begin
            @(negedge clk_i);
            check_outputs();
            instr_valid_i = 1'b0;
            pending       = 1'b0;
        end
    endtask

    // --------------------------------------------------
    // wishbone host
    // --------------------------------------------------
    task automatic bus_cycle(input logic we, input logic [31:0] wdata,
                             output logic [31:0] rdata);
        int waited;
        @(negedge clk_i);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = decode_pkg::MODE_REG_ADDR;
        wb_dat_i = wdata;
        wb_sel_i = 4'hf;
        @(negedge clk_i);
        waited = 1;
        while (!wb_ack_o && waited < 8) begin
            @(negedge clk_i);
            waited++;
        end
        if (!wb_ack_o) begin
            $display("no Wishbone ack within %0d cycles", waited);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end else begin
            check_value("wb_ack_o latency", 64'd1, 64'(waited));
            rdata    = wb_dat_o;
            wb_cyc_i = 1'b0;  // strobe drops at the ack
            wb_stb_i = 1'b0;
            wb_we_i  = 1'b0;
        end
    endtask

    // reserved priv encoding reads back as machine mode
    function automatic logic [31:0] mode_readback_value(input logic [31:0] wval);
        logic [1:0] priv;
        priv = (wval[1:0] == 2'd2) ? 2'd3 : wval[1:0];
        return {28'b0, wval[3], wval[2], priv};
    endfunction

    task automatic mode_write_readback(input logic [31:0] wval);
        logic [31:0] rdata;
        bus_cycle(1'b1, wval, rdata);
        bus_cycle(1'b0, 32'h0, rdata);
        check_value("wb_dat_o", 64'(mode_readback_value(wval)), 64'(rdata));
    endtask

    // --------------------------------------------------
    // data file
    // --------------------------------------------------
    task automatic count_data_lines(output int count);
        int fd;
        int code;
        logic [8*16-1:0]  tag;
        logic [8*256-1:0] rest;
        count = 0;
        fd = $fopen("sim/decode_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open sim/decode_testdata.txt");
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end else begin
            while ($fscanf(fd, "%s", tag) == 1) begin
                if (tag == "W" || tag == "I")
                    count++;
                code = $fgets(rest, fd);
            end
            $fclose(fd);
        end
    endtask

    task automatic run_data_file();
        int fd;
        int code;
        logic [8*16-1:0]  tag;
        logic [8*256-1:0] rest;
        logic [31:0]      wval;
        fd = $fopen("sim/decode_testdata.txt", "r");
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "#") begin
                code = $fgets(rest, fd);
            end else if (tag == "W") begin
                code = $fscanf(fd, "%h", wval);
                flush_pending();
                mode_write_readback(wval);
            end else if (tag == "I") begin
                code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h", new_instr, new_fu,
                               new_op, new_rd, new_rs1, new_rs2, new_imm, new_use_imm,
                               new_use_pc, new_ex_valid, new_ex_cause);
                if (code != 11) begin
                    $display("malformed instruction line in data file");
                    $display("TEST RESULT: FAIL");
                    $fatal(1);
                end else begin
                    drive_instr();
                end
            end else begin
                $display("unknown line tag in data file");
                $display("TEST RESULT: FAIL");
                $fatal(1);
            end
        end
        $fclose(fd);
    endtask

    initial begin
        rst_i         = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = 32'h0;
        wb_cyc_i      = 1'b0;
        wb_stb_i      = 1'b0;
        wb_we_i       = 1'b0;
        wb_adr_i      = 2'b0;
        wb_dat_i      = 32'h0;
        wb_sel_i      = 4'h0;

        count_data_lines(line_count);
        cycle_limit = 4 * line_count + 50;

        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        run_data_file();
        flush_pending();

        // bound assertion failures count as errors too
        error_count += decode_stage_inst.decode_stage_sva_inst.fail_count;

        if (error_count == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/decode_testdata.txt ====
# I instr fu op rd rs1 rs2 imm use_imm use_pc ex_valid ex_cause (all hex, fu/op as enum codes)
# W mode (bit 3 tsr, bit 2 tw, bits 1:0 priv)
# alu reg-reg, reg-imm and shifts, back to back
I 002081b3 1 00 03 01 02 0000000000000000 0 0 0 00
I 407302b3 1 01 05 06 07 0000000000000000 0 0 0 00
I 40c5d533 1 09 0a 0b 0c 0000000000000000 0 0 0 00
I 00943233 1 03 04 08 09 0000000000000000 0 0 0 00
I fff10093 1 00 01 02 00 ffffffffffffffff 1 0 0 00
I 7ff44393 1 04 07 08 00 00000000000007ff 1 0 0 00
I 03f21193 1 07 03 04 00 000000000000003f 1 0 0 00
I 40535293 1 09 05 06 00 0000000000000405 1 0 0 00
I 04009113 1 07 02 01 00 0000000000000040 1 0 1 02
# loads, stores, branches, jumps, upper immediates
I ff813303 2 0d 06 02 00 fffffffffffffff8 1 0 0 00
I 0100c483 2 0e 09 01 00 0000000000000010 1 0 0 00
I fe543823 3 14 00 08 05 fffffffffffffff0 1 0 0 00
I 7e30a223 3 13 00 01 03 00000000000007e4 1 0 0 00
I fe208ee3 4 15 00 01 02 fffffffffffffffc 1 0 0 00
I 0041f0e3 4 1a 00 03 04 0000000000000800 1 0 0 00
I 00629963 4 16 00 05 06 0000000000000012 1 0 0 00
I fffff0ef 4 00 01 00 00 fffffffffffffffe 1 0 0 00
I 010012ef 4 00 05 00 00 0000000000001010 1 0 0 00
I 008280e7 4 1b 01 05 00 0000000000000008 1 0 0 00
I 80000137 1 00 02 00 00 ffffffff80000000 1 0 0 00
I 12345197 1 00 03 00 00 0000000012345000 1 1 0 00
# system group, machine mode after reset
I 00000073 5 00 00 00 00 0000000000000000 0 0 1 0b
I 00100073 5 00 00 00 00 0000000000000000 0 0 1 03
I 30200073 5 1d 00 00 00 0000000000000000 0 0 0 00
I 10200073 5 1c 00 00 00 0000000000000000 0 0 0 00
I 10500073 5 1e 00 00 00 0000000000000000 0 0 0 00
W 00000001
I 00000073 5 00 00 00 00 0000000000000000 0 0 1 09
I 10200073 5 1c 00 00 00 0000000000000000 0 0 0 00
I 10500073 5 1e 00 00 00 0000000000000000 0 0 0 00
I 30200073 5 1d 00 00 00 0000000000000000 0 0 1 02
W 0000000d
I 10200073 5 00 00 00 00 0000000000000000 0 0 1 02
I 10500073 5 00 00 00 00 0000000000000000 0 0 1 02
W 00000000
I 00000073 5 00 00 00 00 0000000000000000 0 0 1 08
I 10200073 5 00 00 00 00 0000000000000000 0 0 1 02
I 10500073 5 00 00 00 00 0000000000000000 0 0 1 02
I 30200073 5 1d 00 00 00 0000000000000000 0 0 1 02
W 00000006
I 10500073 5 1e 00 00 00 0000000000000000 0 0 0 00
I 00000073 5 00 00 00 00 0000000000000000 0 0 1 0b
I 30001073 5 00 00 00 00 0000000000000000 0 0 1 02
I 0000007f 0 00 00 00 00 0000000000000000 0 0 1 02

// ==== sim.f ====
hdl/decode_pkg.sv
hdl/priv_mode_regs.sv
hdl/opcode_decoder.sv
hdl/imm_gen.sv
hdl/decode_stage.sv
sim/decode_stage_sva.sv
sim/decode_stage_tb.sv
